// ==== include/bp_consts.svh ====
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// log2 of the number of target buffer entries
`define BP_ENTRY_BITS 3

// local history length per entry, gives 2**BP_HIST_BITS counters
`define BP_HIST_BITS 2

// counter value that flush and reset load
`define BP_CNT_INIT 2'b01

// fixed instruction size used for the fall-through pc
`define BP_INSN_BYTES 32'd4

`endif

// ==== source/rv32i_types.sv ====
package rv32i_types;

  // one pc or target address
  typedef logic [31:0] rv32i_word;

  // answer returned to fetch in the same cycle
  typedef struct packed {
    logic      hit;     // pc found in the target buffer
    logic      taken;   // predicted direction
    rv32i_word target;  // predicted target, valid with hit
    logic      is_jal;  // entry belongs to a jal
  } bp_predict_t;

  // resolved control-flow instruction from the memory stage
  typedef struct packed {
    logic      valid;        // single-cycle strobe
    rv32i_word pc;
    rv32i_word target;       // resolved target address
    logic      taken;        // resolved direction
    logic      is_branch;
    logic      is_jal;
    logic      pred_taken;   // what fetch predicted
    rv32i_word pred_target;  // target fetch used
  } bp_resolve_t;

  // command from the resolve controller to the target buffer
  typedef struct packed {
    logic      replace;  // allocate a new entry
    logic      update;   // train the matching entry
    rv32i_word pc;
    rv32i_word target;
    logic      taken;
    logic      is_jal;
  } bp_cmd_t;

endpackage

// ==== source/branch_history_table.sv ====
`timescale 1ns/1ps
`include "bp_consts.svh"

module branch_history_table (
  input  logic clk,
  input  logic rst,
  input  logic update,         // train with branch_result
  input  logic flush,          // entry is reallocated
  input  logic branch_result,  // resolved direction
  output logic prediction
);

  localparam int num_cnt = 1 << `BP_HIST_BITS;

  logic [`BP_HIST_BITS-1:0] hist_q;    // newest outcome at bit 0
  logic [1:0]               cnt_q [num_cnt];
  logic [1:0]               cnt_sel;   // counter picked by the history

  // two-bit saturating step toward the outcome
  function automatic logic [1:0] step_cnt(input logic [1:0] cnt, input logic taken);
    logic [1:0] nxt;
    nxt = cnt;
    if (taken && cnt != 2'b11) begin
      nxt = cnt + 2'b01;
    end else if (!taken && cnt != 2'b00) begin
      nxt = cnt - 2'b01;
    end
    return nxt;
  endfunction

  assign cnt_sel    = cnt_q[hist_q];
  assign prediction = cnt_sel[1];  // msb set means taken

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      hist_q <= '0;
      for (int i = 0; i < num_cnt; i++) begin
        cnt_q[i] <= `BP_CNT_INIT;  // weakly not taken
      end
    end else if (update) begin
      cnt_q[hist_q] <= step_cnt(cnt_sel, branch_result);
      if (`BP_HIST_BITS > 1) begin
        hist_q <= {hist_q[`BP_HIST_BITS-2:0], branch_result};
      end else begin
        hist_q <= branch_result;
      end
    end
  end

endmodule

// ==== source/btb_bht.sv ====
`timescale 1ns/1ps
`include "bp_consts.svh"

module btb_bht
  import rv32i_types::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rv32i_word   fetch_pc,  // lookup address from fetch
  input  bp_cmd_t     cmd,       // allocate or train request
  output bp_predict_t predict,
  output logic        mem_hit    // cmd.pc is present
);

  localparam int num_entries = 1 << `BP_ENTRY_BITS;

  // payload of one buffer entry
  typedef struct packed {
    rv32i_word tag;
    rv32i_word target;
    logic      is_jal;
  } btb_entry_t;

  btb_entry_t               entry_q     [num_entries];
  logic                     valid_q     [num_entries];
  logic [`BP_ENTRY_BITS-1:0] replace_ptr;

  logic fetch_match [num_entries];
  logic cmd_match   [num_entries];
  logic hist_pred   [num_entries];

  // control state, valid bits and round-robin pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      replace_ptr <= '0;
      for (int i = 0; i < num_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (cmd.replace) begin
      valid_q[replace_ptr] <= 1'b1;
      replace_ptr          <= replace_ptr + 1'b1;  // wraps at num_entries
    end
  end

  // entry payload needs no reset, valid guards it
  always_ff @(posedge clk) begin
    if (cmd.replace) begin
      entry_q[replace_ptr].tag    <= cmd.pc;
      entry_q[replace_ptr].target <= cmd.target;
      entry_q[replace_ptr].is_jal <= cmd.is_jal;
    end
  end

  genvar j;
  generate
    for (j = 0; j < num_entries; j++) begin : g_entry
      assign fetch_match[j] = valid_q[j] && (entry_q[j].tag == fetch_pc);
      assign cmd_match[j]   = valid_q[j] && (entry_q[j].tag == cmd.pc);

      branch_history_table u_bht (
        .clk           (clk),
        .rst           (rst),
        .update        (cmd.update && cmd_match[j]),
        .flush         (cmd.replace && (replace_ptr == j)),
        .branch_result (cmd.taken),
        .prediction    (hist_pred[j])
      );
    end
  endgenerate

  // tags are unique, so at most one entry matches each address
  always_comb begin
    predict = '0;
    mem_hit = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      if (fetch_match[i]) begin
        predict.hit    = 1'b1;
        predict.target = entry_q[i].target;
        predict.is_jal = entry_q[i].is_jal;
        predict.taken  = entry_q[i].is_jal | hist_pred[i];  // jal always taken
      end
      if (cmd_match[i]) begin
        mem_hit = 1'b1;
      end
    end
  end

endmodule

// ==== source/branch_resolve_ctrl.sv ====
`timescale 1ns/1ps
`include "bp_consts.svh"

module branch_resolve_ctrl
  import rv32i_types::*;
(
  input  bp_resolve_t resolve,      // memory-stage report
  input  logic        mem_hit,      // resolve.pc already in the buffer
  output bp_cmd_t     cmd,
  output logic        mispredict,
  output rv32i_word   redirect_pc
);

  logic is_ctrl;      // instruction the buffer tracks
  logic dir_wrong;    // direction differs from fetch
  logic target_wrong; // both taken but target differs
  rv32i_word fall_pc;

  assign is_ctrl = resolve.is_branch || resolve.is_jal;

  // only taken misses get an entry, a not-taken miss looks like any other insn
  assign cmd.replace = resolve.valid && resolve.taken && is_ctrl && !mem_hit;

  // jal entries have a fixed direction and are never trained
  assign cmd.update  = resolve.valid && resolve.is_branch && !resolve.is_jal && mem_hit;

  assign cmd.pc     = resolve.pc;
  assign cmd.target = resolve.target;
  assign cmd.taken  = resolve.taken;
  assign cmd.is_jal = resolve.is_jal;

  assign dir_wrong    = resolve.pred_taken != resolve.taken;
  assign target_wrong = resolve.pred_taken && resolve.taken &&
                        (resolve.pred_target != resolve.target);

  assign mispredict = resolve.valid && (dir_wrong || target_wrong);

  assign fall_pc     = resolve.pc + `BP_INSN_BYTES;
  assign redirect_pc = resolve.taken ? resolve.target : fall_pc;

endmodule

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor
  import rv32i_types::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rv32i_word   fetch_pc,     // pc of the fetch stage
  input  bp_resolve_t resolve,      // strobe from the memory stage
  output bp_predict_t predict,      // same-cycle answer to fetch
  output logic        mispredict,   // one-cycle flush request
  output rv32i_word   redirect_pc   // where fetch restarts
);

  bp_cmd_t cmd;      // allocate or train request
  logic    mem_hit;  // resolve.pc lookup result

  branch_resolve_ctrl u_ctrl (
    .resolve     (resolve),
    .mem_hit     (mem_hit),
    .cmd         (cmd),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc)
  );

  btb_bht u_btb (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .cmd      (cmd),
    .predict  (predict),
    .mem_hit  (mem_hit)
  );

endmodule

// ==== tb/bp_properties.sv ====
`timescale 1ns/1ps

module bp_properties
  import rv32i_types::*;
(
  input logic        clk,
  input logic        rst,
  input bp_cmd_t     cmd,      // request into the buffer
  input bp_predict_t predict   // answer to fetch
);

  // allocate and train are exclusive
  a_cmd_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(cmd.replace && cmd.update)
  ) else $error("replace and update are high in the same cycle");

  // nothing can hit right after a reset edge
  a_no_hit_after_rst: assert property (
    @(posedge clk) rst |=> !predict.hit
  ) else $error("predict.hit is high in the cycle after reset");

  // a taken prediction needs a buffer entry
  a_taken_needs_hit: assert property (
    @(posedge clk) disable iff (rst) predict.taken |-> predict.hit
  ) else $error("predict.taken is high without predict.hit");

endmodule

bind btb_bht bp_properties u_props (
  .clk     (clk),
  .rst     (rst),
  .cmd     (cmd),
  .predict (predict)
);

// ==== tb/branch_predictor_tb.sv ====
`timescale 1ns/1ps
`include "bp_consts.svh"

module branch_predictor_tb
  import rv32i_types::*;
();

  localparam int clk_period    = 8;
  localparam int num_entries   = 1 << `BP_ENTRY_BITS;
  localparam int num_cnt       = 1 << `BP_HIST_BITS;
  localparam int n_hist_random = 64;
  localparam int n_hist_period = 40;
  localparam int n_mixed       = 400;
  localparam int pool_size     = 12;  // more pcs than entries, forces eviction
  localparam int planned_cycles = 5 + 9 + 3 + 7 + 1 + n_hist_random + n_hist_period +
                                  6 + 2 * (num_entries + 1) + 4 + n_mixed + 1;

  logic        clk;
  logic        rst;
  rv32i_word   fetch_pc;
  bp_resolve_t resolve;
  bp_predict_t predict;
  logic        mispredict;
  rv32i_word   redirect_pc;

  string test_name;
  event  drove;  // inputs changed on this falling edge

  // reference table state
  logic      m_valid  [num_entries];
  rv32i_word m_tag    [num_entries];
  rv32i_word m_target [num_entries];
  logic      m_jal    [num_entries];
  int        m_hist   [num_entries];
  int        m_cnt    [num_entries][num_cnt];
  int        m_ptr;

  branch_predictor DUT (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc    (fetch_pc),
    .resolve     (resolve),
    .predict     (predict),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic void model_reset();
    m_ptr = 0;
    for (int i = 0; i < num_entries; i++) begin
      m_valid[i] = 1'b0;
      m_hist[i]  = 0;
      for (int c = 0; c < num_cnt; c++) begin
        m_cnt[i][c] = 1;  // weakly not taken
      end
    end
  endfunction

  function automatic int model_find(input rv32i_word pc);
    for (int i = 0; i < num_entries; i++) begin
      if (m_valid[i] && m_tag[i] == pc) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic bp_predict_t model_predict(input rv32i_word pc);
    bp_predict_t p;
    int idx;
    p   = '0;
    idx = model_find(pc);
    if (idx >= 0) begin
      p.hit    = 1'b1;
      p.target = m_target[idx];
      p.is_jal = m_jal[idx];
      p.taken  = m_jal[idx] || (m_cnt[idx][m_hist[idx]] >= 2);
    end
    return p;
  endfunction

  function automatic logic model_mispredict(input bp_resolve_t r);
    if (!r.valid) begin
      return 1'b0;
    end
    if (r.taken) begin
      return !r.pred_taken || (r.pred_target != r.target);
    end
    return r.pred_taken;
  endfunction

  function automatic rv32i_word model_redirect(input bp_resolve_t r);
    return r.taken ? r.target : r.pc + 32'd4;
  endfunction

  // table change that the DUT makes at the next rising edge
  function automatic void model_apply(input bp_resolve_t r);
    int idx;
    int h;
    idx = model_find(r.pc);
    if (!r.valid) begin
      return;
    end
    if (r.taken && (r.is_branch || r.is_jal) && idx < 0) begin
      m_valid[m_ptr]  = 1'b1;
      m_tag[m_ptr]    = r.pc;
      m_target[m_ptr] = r.target;
      m_jal[m_ptr]    = r.is_jal;
      m_hist[m_ptr]   = 0;
      for (int c = 0; c < num_cnt; c++) begin
        m_cnt[m_ptr][c] = 1;
      end
      m_ptr = (m_ptr + 1) % num_entries;
    end else if (r.is_branch && !r.is_jal && idx >= 0) begin
      h = m_hist[idx];
      if (r.taken && m_cnt[idx][h] < 3) begin
        m_cnt[idx][h] = m_cnt[idx][h] + 1;
      end else if (!r.taken && m_cnt[idx][h] > 0) begin
        m_cnt[idx][h] = m_cnt[idx][h] - 1;
      end
      m_hist[idx] = (h * 2 + (r.taken ? 1 : 0)) % num_cnt;  // newest outcome at bit 0
    end
  endfunction

  function automatic string pred_text(input bp_predict_t p);
    return $sformatf("hit=%0b taken=%0b target=%h is_jal=%0b",
                     p.hit, p.taken, p.target, p.is_jal);
  endfunction

  task automatic check_predict(input string name, input bp_predict_t exp,
                               input bp_predict_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s predict: expected %s, actual %s",
               name, pred_text(exp), pred_text(act));
      $display("TEST FAILED");
      $fatal(1, "predict mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  function automatic bp_resolve_t branch_res(input rv32i_word pc, input rv32i_word target,
                                             input logic taken, input logic is_branch,
                                             input logic is_jal, input logic pred_taken,
                                             input rv32i_word pred_target);
    bp_resolve_t r;
    r.valid       = 1'b1;
    r.pc          = pc;
    r.target      = target;
    r.taken       = taken;
    r.is_branch   = is_branch;
    r.is_jal      = is_jal;
    r.pred_taken  = pred_taken;
    r.pred_target = pred_target;
    return r;
  endfunction

  function automatic bp_predict_t pred_of(input logic hit, input logic taken,
                                          input rv32i_word target, input logic is_jal);
    bp_predict_t p;
    p.hit    = hit;
    p.taken  = taken;
    p.target = target;
    p.is_jal = is_jal;
    return p;
  endfunction

  function automatic logic rand_bit();
    return ($urandom() % 2) == 1;
  endfunction

  function automatic rv32i_word pool_pc(input int k);
    return 32'h0000_8000 + rv32i_word'(k) * 32'd16;
  endfunction

  function automatic rv32i_word pool_tgt(input int k);
    return 32'h0001_0000 + rv32i_word'(k) * 32'd32;
  endfunction

  task automatic drive(input string name, input rv32i_word pc, input bp_resolve_t res);
    @(negedge clk);
    fetch_pc  = pc;
    resolve   = res;
    test_name = name;
    -> drove;
  endtask

  // branch resolve carrying what fetch predicted for the same pc
  task automatic drive_branch(input string name, input rv32i_word pc,
                              input rv32i_word target, input logic taken);
    bp_predict_t p;
    @(negedge clk);
    p         = model_predict(pc);
    fetch_pc  = pc;
    resolve   = branch_res(pc, target, taken, 1'b1, 1'b0, p.taken, p.target);
    test_name = name;
    -> drove;
  endtask

  task automatic apply_reset(input rv32i_word hold_pc);
    rst      = 1'b1;
    fetch_pc = hold_pc;  // lookup stays on this pc through the reset
    resolve  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    model_reset();
  endtask

  initial begin : compare
    bp_predict_t exp_pred;
    forever begin
      @(drove);
      #2;  // outputs settled after the falling-edge drive
      exp_pred = model_predict(fetch_pc);
      check_predict(test_name, exp_pred, predict);
      check_flag({test_name, " mispredict"}, model_mispredict(resolve), mispredict);
      check_word({test_name, " redirect_pc"}, model_redirect(resolve), redirect_pc);
      model_apply(resolve);
    end
  end

  task automatic test_reset_state();
    rv32i_word w;
    for (int i = 0; i < 8; i++) begin
      w = $urandom();
      drive("reset_lookup", w & 32'hffff_fffc, '0);
      #2;
      check_predict("reset_lookup", pred_of(1'b0, 1'b0, '0, 1'b0), predict);
    end
    drive("reset_unknown_taken", 32'h100,
          branch_res(32'h100, 32'h200, 1'b1, 1'b1, 1'b0, 1'b0, '0));
    #2;
    check_flag("reset_unknown_taken mispredict", 1'b1, mispredict);
    check_word("reset_unknown_taken redirect_pc", 32'h200, redirect_pc);
  endtask

  task automatic test_allocate();
    drive("alloc_lookup", 32'h100, '0);
    #2;
    check_predict("alloc_lookup", pred_of(1'b1, 1'b0, 32'h200, 1'b0), predict);
    drive("alloc_not_taken", 32'h300,
          branch_res(32'h300, 32'h380, 1'b0, 1'b1, 1'b0, 1'b0, '0));
    drive("alloc_not_taken_lookup", 32'h300, '0);
    #2;
    check_flag("alloc_not_taken_lookup hit", 1'b0, predict.hit);
  endtask

  task automatic test_jal();
    drive("jal_alloc", 32'h400, branch_res(32'h400, 32'h480, 1'b1, 1'b0, 1'b1, 1'b0, '0));
    drive("jal_lookup", 32'h400, '0);
    #2;
    check_predict("jal_lookup", pred_of(1'b1, 1'b1, 32'h480, 1'b1), predict);
    for (int i = 0; i < 4; i++) begin
      drive("jal_resolve", 32'h400,
            branch_res(32'h400, 32'h480, 1'b1, 1'b0, 1'b1, 1'b1, 32'h480));
      #2;
      check_flag("jal_resolve mispredict", 1'b0, mispredict);
    end
    drive("jal_lookup_again", 32'h400, '0);
    #2;
    check_predict("jal_lookup_again", pred_of(1'b1, 1'b1, 32'h480, 1'b1), predict);
  endtask

  task automatic test_history();
    logic t;
    drive_branch("hist_alloc", 32'h500, 32'h540, 1'b1);
    for (int i = 0; i < n_hist_random; i++) begin
      drive_branch("hist_random", 32'h500, 32'h540, rand_bit());
    end
    for (int i = 0; i < n_hist_period; i++) begin
      t = (i % 2) == 0;  // taken, not taken, taken, ...
      drive_branch("hist_period2", 32'h500, 32'h540, t);
      if (i >= n_hist_period - 16) begin
        #2;
        check_flag("hist_period2 taken", t, predict.taken);
        check_flag("hist_period2 mispredict", 1'b0, mispredict);
      end
    end
  endtask

  task automatic test_replace();
    @(negedge clk);
    apply_reset(32'h500);  // trained entry, must be gone after reset
    drive_branch("replace_alloc", pool_pc(0), pool_tgt(0), 1'b1);
    repeat (4) drive_branch("replace_train", pool_pc(0), pool_tgt(0), 1'b1);
    for (int k = 1; k <= num_entries; k++) begin
      drive_branch("replace_alloc", pool_pc(k), pool_tgt(k), 1'b1);
    end
    drive("replace_evicted", pool_pc(0), '0);
    #2;
    check_flag("replace_evicted hit", 1'b0, predict.hit);
    for (int k = 1; k < num_entries; k++) begin
      drive("replace_kept", pool_pc(k), '0);
      #2;
      check_flag("replace_kept hit", 1'b1, predict.hit);
    end
    drive("replace_flushed", pool_pc(num_entries), '0);
    #2;
    check_predict("replace_flushed",
                  pred_of(1'b1, 1'b0, pool_tgt(num_entries), 1'b0), predict);
  endtask

  task automatic test_mixed();
    bp_resolve_t r;
    rv32i_word   w;
    int          k;
    int          f;
    for (int i = 0; i < n_mixed; i++) begin
      k             = $urandom_range(pool_size - 1, 0);
      f             = $urandom_range(pool_size - 1, 0);
      w             = $urandom();
      r             = '0;
      r.valid       = ($urandom() % 4) != 0;  // most cycles carry a resolve
      r.pc          = pool_pc(k);
      r.target      = (($urandom() % 8) == 0) ? (w & 32'hffff_fffc) : pool_tgt(k);
      r.taken       = rand_bit();
      r.is_branch   = rand_bit();
      r.is_jal      = rand_bit();
      r.pred_taken  = rand_bit();
      r.pred_target = rand_bit() ? r.target : pool_tgt(f);
      drive("mixed", pool_pc(f), r);
    end
  endtask

  initial begin
    #((planned_cycles + 100) * clk_period);
    $display("watchdog timeout, tests did not finish within %0d cycles", planned_cycles + 100);
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    void'($urandom(32'h141e_b23c));
    apply_reset('0);
    test_reset_state();
    test_allocate();
    test_jal();
    test_history();
    test_replace();
    test_mixed();
    drive("final_idle", '0, '0);
    #3;
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/rv32i_types.sv
source/branch_history_table.sv
source/btb_bht.sv
source/branch_resolve_ctrl.sv
source/branch_predictor.sv
tb/bp_properties.sv
tb/branch_predictor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module branch_predictor_tb -o bp_sim -f sources.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

if [ ! -x ./obj_dir/bp_sim ]; then
  echo "simulation binary missing after build"
  exit 1
fi

./obj_dir/bp_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
